// File: list.f
+incdir+src
src/fifo_status_pkg.sv
src/fifo_memory_pkg.sv
src/wrapping_counter.sv
src/fifo_controller.sv
src/fifo_ram.sv
src/fifo_queue.sv
verification/fifo_queue_sva.sv
verification/fifo_queue_tb.sv

// File: src/fifo_controller.sv
// ====================
// Queue controller: accept logic, level, flags,
// error pulses and storage requests
// ====================

`include "fifo_settings.svh"

module fifo_controller (
  input  logic                             clock,
  input  logic                             resetn,
  input  logic                             flush,
  // Write side
  input  logic                             write_enable,
  input  logic [`FIFO_WIDTH-1:0]           write_data,
  // Read side
  input  logic                             read_enable,
  // Level thresholds, quasi-static
  input  fifo_status_pkg::fifo_thresholds_t thresholds,
  // Pointers from the two counters
  input  fifo_status_pkg::fifo_pointer_t   write_pointer,
  input  fifo_status_pkg::fifo_pointer_t   read_pointer,
  // Counter controls
  output logic                             write_increment,
  output logic                             read_increment,
  output logic                             read_load,
  // Flags and pulses
  output fifo_status_pkg::fifo_status_t    status,
  output fifo_status_pkg::fifo_errors_t    errors,
  // Storage requests
  output fifo_memory_pkg::memory_write_t   memory_write,
  output fifo_memory_pkg::memory_read_t    memory_read
);

  import fifo_status_pkg::*;

  localparam fifo_level_t DEPTH_LEVEL       = fifo_level_t'(`FIFO_DEPTH);
  localparam fifo_level_t ALMOST_FULL_LEVEL = fifo_level_t'(`FIFO_DEPTH - 1);

  logic        same_address;
  logic        same_lap;
  logic        empty;
  logic        full;
  logic        do_write;
  logic        do_read;
  fifo_level_t lap_offset;
  fifo_level_t level;

  // Pointer comparison
  assign same_address = write_pointer.address == read_pointer.address;
  assign same_lap     = write_pointer.lap == read_pointer.lap;

  // Same address: empty on the same lap, full one lap apart
  assign empty = same_address && same_lap;
  assign full  = same_address && !same_lap;

  // Address gap, plus the depth once the writer is a lap ahead
  // (depth need not be a power of two, so the pointers cannot just be subtracted)
  assign lap_offset = same_lap ? '0 : DEPTH_LEVEL;
  assign level      = fifo_level_t'(write_pointer.address)
                    - fifo_level_t'(read_pointer.address)
                    + lap_offset;

  // Accepted strobes, flush blocks both
  assign do_write = write_enable && !full && !flush;
  assign do_read  = read_enable && !empty && !flush;

  // Counter controls
  assign write_increment = do_write;
  assign read_increment  = do_read;
  // Flush pulls the read pointer up to the write pointer
  assign read_load       = flush;

  // Status outputs
  always_comb begin
    status.level                  = level;
    status.empty                  = empty;
    status.almost_empty           = level == fifo_level_t'(1);
    status.full                   = full;
    status.almost_full            = level == ALMOST_FULL_LEVEL;
    status.lower_threshold_status = level <= thresholds.lower;
    status.upper_threshold_status = level >= thresholds.upper;
  end

  // Storage requests from pointer addresses
  assign memory_write.enable  = do_write;
  assign memory_write.address = write_pointer.address;
  assign memory_write.data    = write_data;
  assign memory_read.enable   = do_read;
  assign memory_read.address  = read_pointer.address;

  // Rejected strobes, one-cycle pulses
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      errors <= '0;
    end else begin
      // No errors while flushing
      errors.write_miss <= write_enable && full && !flush;
      errors.read_error <= read_enable && empty && !flush;
    end
  end

endmodule

// File: src/fifo_memory_pkg.sv
// ====================
// Request types of the storage array ports
// ====================

`include "fifo_settings.svh"

package fifo_memory_pkg;

  // Write port request
  typedef struct packed {
    logic                           enable;
    logic [`FIFO_POINTER_WIDTH-1:0] address;
    logic [`FIFO_WIDTH-1:0]         data;
  } memory_write_t;

  // Read port request, data returns one cycle later
  typedef struct packed {
    logic                           enable;
    logic [`FIFO_POINTER_WIDTH-1:0] address;
  } memory_read_t;

endpackage

// File: src/fifo_queue.sv
// ====================
// Synchronous FIFO: controller, pointers, storage
// ====================

`include "fifo_settings.svh"

module fifo_queue (
  input  logic                              clock,
  input  logic                              resetn,
  input  logic                              flush,
  input  logic                              write_enable,
  input  logic [`FIFO_WIDTH-1:0]            write_data,
  input  logic                              read_enable,
  output logic [`FIFO_WIDTH-1:0]            read_data,
  input  fifo_status_pkg::fifo_thresholds_t thresholds,
  output fifo_status_pkg::fifo_status_t     status,
  output fifo_status_pkg::fifo_errors_t     errors
);

  import fifo_status_pkg::*;
  import fifo_memory_pkg::*;

  // Pointers and counter controls
  fifo_pointer_t write_pointer;
  fifo_pointer_t read_pointer;
  logic          write_increment;
  logic          read_increment;
  logic          read_load;

  // Storage requests
  memory_write_t memory_write;
  memory_read_t  memory_read;

  fifo_controller u_controller (
    .clock           (clock),
    .resetn          (resetn),
    .flush           (flush),
    .write_enable    (write_enable),
    .write_data      (write_data),
    .read_enable     (read_enable),
    .thresholds      (thresholds),
    .write_pointer   (write_pointer),
    .read_pointer    (read_pointer),
    .write_increment (write_increment),
    .read_increment  (read_increment),
    .read_load       (read_load),
    .status          (status),
    .errors          (errors),
    .memory_write    (memory_write),
    .memory_read     (memory_read)
  );

  // Write pointer, never loaded
  wrapping_counter #(
    .RANGE (`FIFO_DEPTH)
  ) write_counter (
    .clock       (clock),
    .resetn      (resetn),
    .increment   (write_increment),
    .load_enable (1'b0),
    .load_count  ('0),
    .count       (write_pointer)
  );

  // Read pointer, flush loads the write pointer
  wrapping_counter #(
    .RANGE (`FIFO_DEPTH)
  ) read_counter (
    .clock       (clock),
    .resetn      (resetn),
    .increment   (read_increment),
    .load_enable (read_load),
    .load_count  (write_pointer),
    .count       (read_pointer)
  );

  fifo_ram u_ram (
    .clock        (clock),
    .memory_write (memory_write),
    .memory_read  (memory_read),
    .read_data    (read_data)
  );

endmodule

// File: src/fifo_ram.sv
// ====================
// Dual-port storage array, registered read
// ====================

`include "fifo_settings.svh"

module fifo_ram (
  input  logic                           clock,
  input  fifo_memory_pkg::memory_write_t memory_write,
  input  fifo_memory_pkg::memory_read_t  memory_read,
  output logic [`FIFO_WIDTH-1:0]         read_data
);

  // One word per queue entry
  logic [`FIFO_WIDTH-1:0] storage [`FIFO_DEPTH];

  // Write port
  always_ff @(posedge clock) begin
    if (memory_write.enable) begin
      storage[memory_write.address] <= memory_write.data;
    end
  end

  // Read port, output holds between reads
  // Never the same address as an accepted write in the same cycle
  always_ff @(posedge clock) begin
    if (memory_read.enable) begin
      read_data <= storage[memory_read.address];
    end
  end

endmodule

// File: src/fifo_settings.svh
// ====================
// Queue sizing: entry width, depth and address width
// ====================

`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// Bits per stored entry
`define FIFO_WIDTH 8

// Number of entries, not limited to a power of two
`define FIFO_DEPTH 6

// Address bits, ceiling of log2 of the depth
`define FIFO_POINTER_WIDTH 3

`endif

// File: src/fifo_status_pkg.sv
// ====================
// Pointer, level and status types of the queue
// ====================

`include "fifo_settings.svh"

package fifo_status_pkg;

  // Queue pointer, lap bit above the array address
  typedef struct packed {
    logic                           lap;
    logic [`FIFO_POINTER_WIDTH-1:0] address;
  } fifo_pointer_t;

  // Entry count, 0 up to the full depth
  typedef logic [`FIFO_POINTER_WIDTH:0] fifo_level_t;

  // Programmable level comparisons
  typedef struct packed {
    fifo_level_t lower;
    fifo_level_t upper;
  } fifo_thresholds_t;

  typedef struct packed {
    fifo_level_t level;
    logic        empty;
    logic        almost_empty;
    logic        full;
    logic        almost_full;
    logic        lower_threshold_status;
    logic        upper_threshold_status;
  } fifo_status_t;

  // One-cycle error pulses
  typedef struct packed {
    logic write_miss;
    logic read_error;
  } fifo_errors_t;

endpackage

// File: src/wrapping_counter.sv
// ====================
// Modulo counter with lap bit, increment and load
// ====================

`include "fifo_settings.svh"

module wrapping_counter #(
  parameter int RANGE = `FIFO_DEPTH
) (
  input  logic                          clock,
  input  logic                          resetn,
  input  logic                          increment,
  input  logic                          load_enable,
  input  fifo_status_pkg::fifo_pointer_t load_count,
  output fifo_status_pkg::fifo_pointer_t count
);

  import fifo_status_pkg::*;

  // Highest address before the wrap
  localparam logic [`FIFO_POINTER_WIDTH-1:0] LAST_ADDRESS = `FIFO_POINTER_WIDTH'(RANGE - 1);

  fifo_pointer_t next_count;

  // Step by one, wrap at RANGE instead of the power of two
  always_comb begin
    next_count = count;
    if (count.address == LAST_ADDRESS) begin
      next_count.address = '0;
      // New lap on every wrap
      next_count.lap     = ~count.lap;
    end else begin
      next_count.address = count.address + 1'b1;
    end
  end

  // Load wins over increment
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      count <= '0;
    end else if (load_enable) begin
      count <= load_count;
    end else if (increment) begin
      count <= next_count;
    end
  end

endmodule

// File: verification/fifo_queue_sva.sv
// ====================
// Queue flag and error pulse assertions
// ====================

`include "fifo_settings.svh"

module fifo_queue_sva (
  input logic                           clock,
  input logic                           resetn,
  input logic                           flush,
  input logic                           write_enable,
  input logic                           read_enable,
  input fifo_status_pkg::fifo_status_t status,
  input fifo_status_pkg::fifo_errors_t errors
);

  import fifo_status_pkg::*;

  localparam fifo_level_t DEPTH_LEVEL = fifo_level_t'(`FIFO_DEPTH);

  // Full and empty exclude each other
  full_empty_exclusive: assert property (
    @(posedge clock) disable iff (!resetn) !(status.full && status.empty)
  ) else $error("full and empty are high together");

  // Write miss only after a write into a full queue
  write_miss_cause: assert property (
    @(posedge clock) disable iff (!resetn)
    errors.write_miss |-> $past(write_enable && status.full && !flush)
  ) else $error("write_miss without a write strobe into a full queue");

  // Read error only after a read from an empty queue
  read_error_cause: assert property (
    @(posedge clock) disable iff (!resetn)
    errors.read_error |-> $past(read_enable && status.empty && !flush)
  ) else $error("read_error without a read strobe from an empty queue");

  // Level bounded by the depth
  level_in_range: assert property (
    @(posedge clock) disable iff (!resetn) status.level <= DEPTH_LEVEL
  ) else $error("level above the queue depth");

endmodule

bind fifo_queue fifo_queue_sva u_sva (
  .clock        (clock),
  .resetn       (resetn),
  .flush        (flush),
  .write_enable (write_enable),
  .read_enable  (read_enable),
  .status       (status),
  .errors       (errors)
);

// File: verification/fifo_queue_tb.sv
// ====================
// FIFO testbench with queue model and directed tests
// ====================

`include "fifo_settings.svh"

module fifo_queue_tb;

  import fifo_status_pkg::*;

  localparam int CLOCK_PERIOD = 20;
  localparam int DEPTH        = `FIFO_DEPTH;
  // Cycles of reset and all five tests rounded up
  localparam int TOTAL_CYCLES = 260;

  logic                   clock;
  logic                   resetn;
  logic                   flush;
  logic                   write_enable;
  logic                   read_enable;
  logic [`FIFO_WIDTH-1:0] write_data;
  logic [`FIFO_WIDTH-1:0] read_data;
  fifo_thresholds_t       thresholds;
  fifo_status_t           status;
  fifo_errors_t           errors;

  // Reference queue and expected outputs
  logic [`FIFO_WIDTH-1:0] model_queue [$];
  logic [`FIFO_WIDTH-1:0] expected_read;
  logic                   read_seen;
  logic                   expected_write_miss;
  logic                   expected_read_error;

  integer seed;
  int     test_errors;
  int     passed_tests;
  int     failed_tests;

  fifo_queue u_dut (
    .clock        (clock),
    .resetn       (resetn),
    .flush        (flush),
    .write_enable (write_enable),
    .write_data   (write_data),
    .read_enable  (read_enable),
    .read_data    (read_data),
    .thresholds   (thresholds),
    .status       (status),
    .errors       (errors)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // Watchdog at twice the expected run length
  initial begin
    #(CLOCK_PERIOD * TOTAL_CYCLES * 2);
    $display("Timeout: the tests did not finish in time");
    $display("Regression failed");
    $finish;
  end

  function automatic logic [`FIFO_WIDTH-1:0] random_data();
    return `FIFO_WIDTH'($random(seed));
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  // Outputs against the model state
  task automatic check_state();
    int level;
    level = model_queue.size();
    compare("status.level", level, status.level);
    compare("status.empty", level == 0, status.empty);
    compare("status.almost_empty", level == 1, status.almost_empty);
    compare("status.full", level == DEPTH, status.full);
    compare("status.almost_full", level == DEPTH - 1, status.almost_full);
    compare("status.lower_threshold_status", level <= thresholds.lower,
            status.lower_threshold_status);
    compare("status.upper_threshold_status", level >= thresholds.upper,
            status.upper_threshold_status);
    compare("errors.write_miss", expected_write_miss, errors.write_miss);
    compare("errors.read_error", expected_read_error, errors.read_error);
    // No read data defined before the first accepted read
    if (read_seen) begin
      compare("read_data", expected_read, read_data);
    end
  endtask

  // Predict the effect of one cycle's strobes
  task automatic apply_model(input logic w, input logic r, input logic f,
                             input logic [`FIFO_WIDTH-1:0] d);
    logic was_full;
    logic was_empty;
    was_full            = model_queue.size() == DEPTH;
    was_empty           = model_queue.size() == 0;
    expected_write_miss = w && was_full && !f;
    expected_read_error = r && was_empty && !f;
    if (f) begin
      model_queue.delete();
    end else begin
      if (r && !was_empty) begin
        expected_read = model_queue.pop_front();
        read_seen     = 1'b1;
      end
      if (w && !was_full) begin
        model_queue.push_back(d);
      end
    end
  endtask

  // Drive on the rising edge and check mid-cycle
  task automatic run_cycle(input logic w, input logic r, input logic f,
                           input logic [`FIFO_WIDTH-1:0] d);
    @(posedge clock);
    write_enable <= w;
    read_enable  <= r;
    flush        <= f;
    write_data   <= d;
    @(negedge clock);
    check_state();
    apply_model(w, r, f, d);
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) begin
      passed_tests++;
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Six writes to full and one rejected
  task automatic fill_to_full();
    repeat (DEPTH + 1) begin
      run_cycle(1'b1, 1'b0, 1'b0, random_data());
    end
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    report_test("fill");
  endtask

  // Six reads to empty and one rejected
  task automatic drain_to_empty();
    repeat (DEPTH + 1) begin
      run_cycle(1'b0, 1'b1, 1'b0, '0);
    end
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    report_test("drain");
  endtask

  // Level up to full and back with thresholds 2 and 4
  task automatic sweep_thresholds();
    @(posedge clock);
    thresholds.lower <= fifo_level_t'(2);
    thresholds.upper <= fifo_level_t'(4);
    repeat (DEPTH) begin
      run_cycle(1'b1, 1'b0, 1'b0, random_data());
    end
    repeat (DEPTH) begin
      run_cycle(1'b0, 1'b1, 1'b0, '0);
    end
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    report_test("thresholds");
  endtask

  // Flush with both strobes high and a fresh write and read
  task automatic flush_with_strobes();
    repeat (3) begin
      run_cycle(1'b1, 1'b0, 1'b0, random_data());
    end
    run_cycle(1'b1, 1'b1, 1'b1, random_data());
    run_cycle(1'b1, 1'b0, 1'b0, random_data());
    run_cycle(1'b0, 1'b1, 1'b0, '0);
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    // Flush on an empty queue raises no read error
    run_cycle(1'b1, 1'b1, 1'b1, random_data());
    repeat (DEPTH) begin
      run_cycle(1'b1, 1'b0, 1'b0, random_data());
    end
    // Flush on a full queue raises no write miss
    run_cycle(1'b1, 1'b1, 1'b1, random_data());
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    report_test("flush");
  endtask

  // Random strobes lap the pointers around the depth many times
  task automatic random_wrap();
    logic [31:0] random_bits;
    repeat (200) begin
      random_bits = $random(seed);
      run_cycle(random_bits[0], random_bits[1], 1'b0, random_bits[15:8]);
    end
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    report_test("wrap");
  endtask

  initial begin
    seed                = 32'h1a2d14c6;
    resetn              = 1'b0;
    flush               = 1'b0;
    write_enable        = 1'b0;
    read_enable         = 1'b0;
    write_data          = '0;
    thresholds.lower    = fifo_level_t'(1);
    thresholds.upper    = fifo_level_t'(5);
    read_seen           = 1'b0;
    expected_read       = '0;
    expected_write_miss = 1'b0;
    expected_read_error = 1'b0;
    test_errors         = 0;
    passed_tests        = 0;
    failed_tests        = 0;
    repeat (10) @(posedge clock);
    resetn <= 1'b1;
    fill_to_full();
    drain_to_empty();
    sweep_thresholds();
    flush_with_strobes();
    random_wrap();
    $display("tests ok: %0d, tests with errors: %0d", passed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
